/* logic/mdio_frame_pkg.sv */
// mdio frame field widths, counter width, opcode and engine state enums, engine to bank access
package mdio_frame_pkg;

    // ones required on the line before the start bits
    localparam int preamble_len = 32;

    // frame field widths
    localparam int phy_addr_w = 5;
    localparam int reg_addr_w = 5;
    localparam int data_w = 16;

    // one bit counter covers the preamble run as well as the data field
    localparam int cnt_w = $clog2(preamble_len + 1);

    // clause 22 opcodes, the other two codes are rejected
    typedef enum logic [1:0] {
        op_write = 2'b01,
        op_read  = 2'b10
    } mdio_op_t;

    // frame engine states
    typedef enum logic [3:0] {
        st_idle,
        st_preamble,
        st_start,
        st_opcode,
        st_phy_addr,
        st_reg_addr,
        st_ta,
        st_read_data,
        st_write_data,
        // ignored frame, wait for a fresh preamble
        st_skip
    } mdio_state_t;

    // single cycle register access from engine to bank
    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [reg_addr_w-1:0] addr;
        logic [data_w-1:0]     wdata;
    } reg_access_t;

endpackage

/* logic/phy_regs_pkg.sv */
// management register addresses, id and reset values, bmsr layout, control and status structs
package phy_regs_pkg;

    // register addresses
    localparam logic [4:0] reg_bmcr   = 5'h00;
    localparam logic [4:0] reg_bmsr   = 5'h01;
    localparam logic [4:0] reg_phyid1 = 5'h02;
    localparam logic [4:0] reg_phyid2 = 5'h03;
    localparam logic [4:0] reg_test   = 5'h18;

    // identifier words
    localparam logic [15:0] phyid1_val = 16'h0a5c;
    localparam logic [15:0] phyid2_val = 16'h6c41;

    // autoneg enable (bit 12) and speed 100 (bit 13 set, bit 6 clear)
    localparam logic [15:0] bmcr_reset_val = 16'h3000;

    // fixed bmsr abilities: 100/10 full and half duplex, autoneg ability, extended regs
    localparam logic [15:0] bmsr_caps = 16'h7809;
    localparam int bmsr_link_bit = 2;
    localparam int bmsr_an_done_bit = 5;

    // control levels into the phy core
    typedef struct packed {
        logic       soft_reset;
        logic       loopback;
        logic [1:0] speed_sel;
        logic       autoneg_en;
        logic       power_down;
        logic       isolate;
    } phy_ctrl_t;

    // status levels from the phy core
    typedef struct packed {
        logic link_up;
        logic autoneg_done;
    } phy_status_t;

    // bmcr word to control levels, speed msb sits in bit 6
    function automatic phy_ctrl_t bmcr_to_ctrl(input logic [15:0] bmcr);
        phy_ctrl_t c;
        c.soft_reset = bmcr[15];
        c.loopback   = bmcr[14];
        c.speed_sel  = {bmcr[6], bmcr[13]};
        c.autoneg_en = bmcr[12];
        c.power_down = bmcr[11];
        c.isolate    = bmcr[10];
        return c;
    endfunction

    // control levels back to the bmcr word, unused bits read 0
    function automatic logic [15:0] ctrl_to_bmcr(input phy_ctrl_t c);
        logic [15:0] w;
        w = '0;
        w[15] = c.soft_reset;
        w[14] = c.loopback;
        w[13] = c.speed_sel[0];
        w[12] = c.autoneg_en;
        w[11] = c.power_down;
        w[10] = c.isolate;
        w[6]  = c.speed_sel[1];
        return w;
    endfunction

endpackage

/* logic/mdio_frame_engine.sv */
// mdio frame engine: preamble and start detection, header decode, read shifter, write capture
`timescale 1ns/1ns

module mdio_frame_engine #(
    parameter logic [mdio_frame_pkg::phy_addr_w-1:0] phy_addr = 5'h0c
) (
    input  logic                               mdc,
    input  logic                               rst_n,
    input  logic                               mdio_i,
    output logic                               mdio_o,
    output logic                               mdio_t,
    input  logic [mdio_frame_pkg::data_w-1:0]  rd_data,
    output mdio_frame_pkg::reg_access_t        acc
);
    import mdio_frame_pkg::*;

    mdio_state_t state;
    logic [cnt_w-1:0] bit_cnt;
    // strobes to the bank
    logic rd_q;
    logic wr_q;
    // captured header fields
    mdio_op_t op_q;
    logic op_msb;
    logic [phy_addr_w-2:0] phy_sr;
    logic [reg_addr_w-1:0] addr_q;
    // write data collector and read data shifter
    logic [data_w-1:0] wdata_q;
    logic [data_w-1:0] tx_sr;
    // fields including the bit on the line this cycle
    logic [1:0] op_bits;
    logic [phy_addr_w-1:0] phy_bits;
    logic op_ok;
    logic ones_full;

    assign op_bits = {op_msb, mdio_i};
    assign phy_bits = {phy_sr, mdio_i};
    assign op_ok = (op_bits == op_read) || (op_bits == op_write);
    assign ones_full = (bit_cnt >= cnt_w'(preamble_len));

    assign acc = '{rd: rd_q, wr: wr_q, addr: addr_q, wdata: wdata_q};

    // frame sequencing, strobes and pin control
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_cnt <= '0;
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
            mdio_o  <= 1'b0;
            mdio_t  <= 1'b1;
        end else begin
            // strobes last a single cycle
            rd_q <= 1'b0;
            wr_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (mdio_i) begin
                        state   <= st_preamble;
                        bit_cnt <= cnt_w'(1);
                    end
                end
                st_preamble: begin
                    if (mdio_i) begin
                        // saturate once enough ones are seen
                        if (!ones_full) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (ones_full) begin
                        // this zero is the first start bit
                        state <= st_start;
                    end else begin
                        state   <= st_idle;
                        bit_cnt <= '0;
                    end
                end
                st_start: begin
                    bit_cnt <= '0;
                    // 00 would be a clause 45 start, not served here
                    state <= mdio_i ? st_opcode : st_skip;
                end
                st_opcode: begin
                    if (bit_cnt == cnt_w'(1)) begin
                        bit_cnt <= '0;
                        state   <= op_ok ? st_phy_addr : st_skip;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_phy_addr: begin
                    if (bit_cnt == cnt_w'(phy_addr_w - 1)) begin
                        bit_cnt <= '0;
                        state   <= (phy_bits == phy_addr) ? st_reg_addr : st_skip;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_reg_addr: begin
                    if (bit_cnt == cnt_w'(reg_addr_w - 1)) begin
                        bit_cnt <= '0;
                        state   <= st_ta;
                        // bank answers on the next edge, in time for the second ta bit
                        rd_q    <= (op_q == op_read);
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_ta: begin
                    if (bit_cnt == '0) begin
                        bit_cnt <= cnt_w'(1);
                        // take the line and drive 0 for the second ta bit
                        if (op_q == op_read) begin
                            mdio_t <= 1'b0;
                            mdio_o <= 1'b0;
                        end
                    end else begin
                        bit_cnt <= '0;
                        if (op_q == op_read) begin
                            mdio_o <= rd_data[data_w-1];
                            state  <= st_read_data;
                        end else begin
                            state <= st_write_data;
                        end
                    end
                end
                st_read_data: begin
                    if (bit_cnt == cnt_w'(data_w - 1)) begin
                        // end of bit 0, release the line
                        bit_cnt <= '0;
                        mdio_t  <= 1'b1;
                        mdio_o  <= 1'b0;
                        state   <= st_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mdio_o  <= tx_sr[data_w-1];
                    end
                end
                st_write_data: begin
                    if (bit_cnt == cnt_w'(data_w - 1)) begin
                        bit_cnt <= '0;
                        wr_q    <= 1'b1;
                        state   <= st_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_skip: begin
                    // count a fresh run of ones, any zero restarts it
                    if (mdio_i) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == cnt_w'(preamble_len - 1)) begin
                            state <= st_preamble;
                        end
                    end else begin
                        bit_cnt <= '0;
                    end
                end
                default: begin
                    state   <= st_idle;
                    bit_cnt <= '0;
                end
            endcase
        end
    end

    // header fields and data shifters
    always_ff @(posedge mdc) begin
        case (state)
            st_opcode: begin
                op_msb <= mdio_i;
                op_q   <= mdio_op_t'(op_bits);
            end
            st_phy_addr: begin
                phy_sr <= phy_bits[phy_addr_w-2:0];
            end
            st_reg_addr: begin
                addr_q <= {addr_q[reg_addr_w-2:0], mdio_i};
            end
            st_ta: begin
                // msb goes straight to the pin, the rest waits here
                if (bit_cnt != '0) begin
                    tx_sr <= {rd_data[data_w-2:0], 1'b0};
                end
            end
            st_read_data: begin
                tx_sr <= {tx_sr[data_w-2:0], 1'b0};
            end
            st_write_data: begin
                wdata_q <= {wdata_q[data_w-2:0], mdio_i};
            end
            default: begin
            end
        endcase
    end

    // the pin is only ever driven inside a read turnaround or data field
    ap_pin_owner: assert property (@(posedge mdc) disable iff (!rst_n)
        !mdio_t |-> (state inside {st_ta, st_read_data}));

    ap_strobe_excl: assert property (@(posedge mdc) disable iff (!rst_n)
        !(rd_q && wr_q));

    ap_rd_pulse: assert property (@(posedge mdc) disable iff (!rst_n)
        rd_q |=> !rd_q);

    ap_wr_pulse: assert property (@(posedge mdc) disable iff (!rst_n)
        wr_q |=> !wr_q);

endmodule

/* logic/phy_mgmt_regs.sv */
// clause 22 management register bank: bmcr with self-clearing reset, bmsr, phy ids, test register
`timescale 1ns/1ns

module phy_mgmt_regs (
    input  logic                              mdc,
    input  logic                              rst_n,
    input  mdio_frame_pkg::reg_access_t       acc,
    input  phy_regs_pkg::phy_status_t         phy_status,
    output logic [mdio_frame_pkg::data_w-1:0] rd_data,
    output phy_regs_pkg::phy_ctrl_t           phy_ctrl
);
    import mdio_frame_pkg::*;
    import phy_regs_pkg::*;

    // vendor test register
    logic [data_w-1:0] test_q;
    // latching-low link bit
    logic link_lat;
    // status word as seen this cycle
    logic [data_w-1:0] bmsr_word;
    // read mux output
    logic [data_w-1:0] rd_mux;
    logic bmsr_rd;

    assign bmsr_rd = acc.rd && (acc.addr == reg_bmsr);

    always_comb begin
        bmsr_word = bmsr_caps;
        bmsr_word[bmsr_an_done_bit] = phy_status.autoneg_done;
        bmsr_word[bmsr_link_bit] = link_lat;
    end

    always_comb begin
        case (acc.addr)
            reg_bmcr:   rd_mux = ctrl_to_bmcr(phy_ctrl);
            reg_bmsr:   rd_mux = bmsr_word;
            reg_phyid1: rd_mux = phyid1_val;
            reg_phyid2: rd_mux = phyid2_val;
            reg_test:   rd_mux = test_q;
            // unimplemented addresses read as zero
            default:    rd_mux = '0;
        endcase
    end

    // read data is registered on the strobe
    always_ff @(posedge mdc) begin
        if (acc.rd) begin
            rd_data <= rd_mux;
        end
    end

    // control register
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            phy_ctrl <= bmcr_to_ctrl(bmcr_reset_val);
        end else if (phy_ctrl.soft_reset) begin
            // soft reset holds one cycle, then defaults come back
            phy_ctrl <= bmcr_to_ctrl(bmcr_reset_val);
        end else if (acc.wr && (acc.addr == reg_bmcr)) begin
            phy_ctrl <= bmcr_to_ctrl(acc.wdata);
        end
    end

    // test register
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            test_q <= '0;
        end else if (acc.wr && (acc.addr == reg_test)) begin
            test_q <= acc.wdata;
        end
    end

    // link latch
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            link_lat <= 1'b0;
        end else if (bmsr_rd) begin
            // status read re-arms to the present link level
            link_lat <= phy_status.link_up;
        end else if (!phy_status.link_up) begin
            link_lat <= 1'b0;
        end
    end

    // self-clear must win over any other write
    ap_soft_reset_pulse: assert property (@(posedge mdc) disable iff (!rst_n)
        phy_ctrl.soft_reset |=> !phy_ctrl.soft_reset);

endmodule

/* logic/phy_mgmt_top.sv */
// phy management top: mdio frame engine beside the management register bank
`timescale 1ns/1ns

module phy_mgmt_top #(
    parameter logic [mdio_frame_pkg::phy_addr_w-1:0] phy_addr = 5'h0c
) (
    input  logic                    mdc,
    input  logic                    rst_n,
    // split tristate pad, joined above this level
    input  logic                    mdio_i,
    output logic                    mdio_o,
    output logic                    mdio_t,
    // levels from and to the phy core
    input  phy_regs_pkg::phy_status_t phy_status,
    output phy_regs_pkg::phy_ctrl_t   phy_ctrl
);
    import mdio_frame_pkg::*;

    // engine to bank strobes
    reg_access_t acc;
    // bank answer, one cycle after rd
    logic [data_w-1:0] rd_data;

    mdio_frame_engine #(
        .phy_addr (phy_addr)
    ) mdio_frame_engine_i (
        .mdc     (mdc),
        .rst_n   (rst_n),
        .mdio_i  (mdio_i),
        .mdio_o  (mdio_o),
        .mdio_t  (mdio_t),
        .rd_data (rd_data),
        .acc     (acc)
    );

    phy_mgmt_regs phy_mgmt_regs_i (
        .mdc        (mdc),
        .rst_n      (rst_n),
        .acc        (acc),
        .phy_status (phy_status),
        .rd_data    (rd_data),
        .phy_ctrl   (phy_ctrl)
    );

endmodule

/* bench/mdc_clock_gen.sv */
// testbench clock source and power-on reset
`timescale 1ns/1ns

module mdc_clock_gen #(
    parameter int period_ns = 40,
    parameter int reset_cycles = 3
) (
    output logic mdc,
    output logic rst_n
);

    // free running management clock, low for the first half period
    initial begin
        mdc = 1'b0;
        forever begin
            #(period_ns / 2) mdc = ~mdc;
        end
    end

    // release lands on a falling edge, well away from the sampling edge
    initial begin
        rst_n = 1'b0;
        #(reset_cycles * period_ns) rst_n = 1'b1;
    end

endmodule

/* bench/phy_mgmt_tb.sv */
// phy management testbench: mdio master tasks, register reference model, checking assertions, report
`timescale 1ns/1ns

module phy_mgmt_tb;
    import mdio_frame_pkg::*;
    import phy_regs_pkg::*;

    localparam logic [4:0] dut_phy = 5'h0c;
    localparam logic [4:0] other_phy = 5'h0d;
    localparam logic [4:0] reg_unused = 5'h1f;
    // bmcr bits that hold state, bit 15 always reads back 0
    localparam logic [15:0] bmcr_rw_mask = 16'h7c40;
    // 64 bit times per frame plus check cycles, 34 frames in all
    localparam int frame_cycles = 70;
    localparam int n_frames = 34;
    localparam int timeout_cycles = n_frames * frame_cycles + 200;

    // check windows opened by the stimulus
    typedef struct packed {
        logic reset;
        logic ta1;
        logic ta2;
        logic rd;
        logic ctrl;
        logic ign;
    } chk_t;

    logic mdc;
    logic rst_n;
    logic mdio_i;
    logic mdio_o;
    logic mdio_t;
    phy_status_t phy_status;
    phy_ctrl_t phy_ctrl;

    // master side of the wire
    logic m_oe;
    logic m_out;

    chk_t chk;
    logic [4:0] rd_reg = '0;
    logic [15:0] rd_got = '0;
    logic [15:0] rd_exp = '0;
    phy_ctrl_t ctrl_exp;
    int low_run = 0;
    int cycles = 0;
    int test_fails = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    // reference model: test register, bmcr word, link latch
    logic [15:0] test_m;
    logic [15:0] ctrl_m;
    logic link_m;

    mdc_clock_gen #(
        .period_ns    (40),
        .reset_cycles (3)
    ) mdc_clock_gen_i (
        .mdc   (mdc),
        .rst_n (rst_n)
    );

    phy_mgmt_top #(
        .phy_addr (dut_phy)
    ) phy_mgmt_top_i (
        .mdc        (mdc),
        .rst_n      (rst_n),
        .mdio_i     (mdio_i),
        .mdio_o     (mdio_o),
        .mdio_t     (mdio_t),
        .phy_status (phy_status),
        .phy_ctrl   (phy_ctrl)
    );

    // wired pin, pull-up when nobody drives
    assign mdio_i = !mdio_t ? mdio_o : (m_oe ? m_out : 1'b1);

    // clause 22 bmcr layout, speed select split over bits 6 and 13
    function automatic phy_ctrl_t ctrl_of_word(input logic [15:0] w);
        phy_ctrl_t c;
        c.soft_reset = w[15];
        c.loopback   = w[14];
        c.speed_sel  = {w[6], w[13]};
        c.autoneg_en = w[12];
        c.power_down = w[11];
        c.isolate    = w[10];
        return c;
    endfunction

    // link status in bit 2, autoneg complete in bit 5
    function automatic logic [15:0] bmsr_expect(input logic link, input logic an_done);
        logic [15:0] w;
        w = bmsr_caps;
        w[5] = an_done;
        w[2] = link;
        return w;
    endfunction

    // phy-driven cycles counted at each sampling edge, so the full run
    // is still held when the release is seen
    always @(posedge mdc) begin
        low_run <= mdio_t ? 0 : low_run + 1;
    end

    always @(posedge mdc) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    a_reset_pin: assert property (@(posedge mdc) disable iff (!rst_n) chk.reset |-> mdio_t)
        else begin
            $display("FAIL t=%0t mdio_t: expected 1 got %b", $time, $sampled(mdio_t));
            test_fails = test_fails + 1;
        end

    a_reset_ctrl: assert property (@(posedge mdc) disable iff (!rst_n)
        chk.reset |-> (phy_ctrl == ctrl_of_word(bmcr_reset_val)))
        else begin
            $display("FAIL t=%0t phy_ctrl: expected %h got %h", $time,
                     ctrl_of_word(bmcr_reset_val), $sampled(phy_ctrl));
            test_fails = test_fails + 1;
        end

    a_ta1_released: assert property (@(posedge mdc) disable iff (!rst_n) chk.ta1 |-> mdio_t)
        else begin
            $display("FAIL t=%0t mdio_t in first ta bit: expected 1 got %b", $time,
                     $sampled(mdio_t));
            test_fails = test_fails + 1;
        end

    a_ta2_zero: assert property (@(posedge mdc) disable iff (!rst_n)
        chk.ta2 |-> (!mdio_t && !mdio_o))
        else begin
            $display("FAIL t=%0t {mdio_t,mdio_o} in second ta bit: expected 00 got %b%b",
                     $time, $sampled(mdio_t), $sampled(mdio_o));
            test_fails = test_fails + 1;
        end

    // every read drives the pin for the second ta bit plus 16 data bits
    a_drive_len: assert property (@(posedge mdc) disable iff (!rst_n)
        $rose(mdio_t) |-> (low_run == 17))
        else begin
            $display("FAIL t=%0t mdio_t low cycles: expected 17 got %0d", $time,
                     $sampled(low_run));
            test_fails = test_fails + 1;
        end

    a_read_data: assert property (@(posedge mdc) disable iff (!rst_n)
        chk.rd |-> (rd_got == rd_exp))
        else begin
            $display("FAIL t=%0t read data of reg %h: expected %h got %h", $time, rd_reg,
                     rd_exp, rd_got);
            test_fails = test_fails + 1;
        end

    a_ctrl: assert property (@(posedge mdc) disable iff (!rst_n)
        chk.ctrl |-> (phy_ctrl == ctrl_exp))
        else begin
            $display("FAIL t=%0t phy_ctrl: expected %h got %h", $time, ctrl_exp,
                     $sampled(phy_ctrl));
            test_fails = test_fails + 1;
        end

    a_ign_quiet: assert property (@(posedge mdc) disable iff (!rst_n) chk.ign |-> mdio_t)
        else begin
            $display("FAIL t=%0t mdio_t in ignored frame: expected 1 got %b", $time,
                     $sampled(mdio_t));
            test_fails = test_fails + 1;
        end

    task automatic drive_bit(input logic b);
        @(negedge mdc);
        m_oe = 1'b1;
        m_out = b;
    endtask

    // preamble, start bits, opcode and both addresses
    task automatic send_header(input logic [1:0] op, input logic [4:0] phy,
                               input logic [4:0] ra);
        logic [13:0] hdr;
        hdr = {2'b01, op, phy, ra};
        repeat (preamble_len) drive_bit(1'b1);
        for (int i = 13; i >= 0; i--) begin
            drive_bit(hdr[i]);
        end
    endtask

    task automatic write_frame(input logic [1:0] op, input logic [4:0] phy,
                               input logic [4:0] ra, input logic [15:0] wd);
        send_header(op, phy, ra);
        // master owns the turnaround on a write
        drive_bit(1'b1);
        drive_bit(1'b0);
        for (int i = 15; i >= 0; i--) begin
            drive_bit(wd[i]);
        end
    endtask

    task automatic read_frame(input logic [4:0] phy, input logic [4:0] ra,
                              output logic [15:0] rd);
        logic own;
        own = (phy == dut_phy);
        rd = '0;
        send_header(op_read, phy, ra);
        // let go of the line, first ta bit comes from the pull-up
        @(negedge mdc);
        m_oe = 1'b0;
        chk.ta1 = own;
        @(negedge mdc);
        chk.ta1 = 1'b0;
        chk.ta2 = own;
        // data is stable at the falling edge, msb first
        for (int i = 0; i < 16; i++) begin
            @(negedge mdc);
            chk.ta2 = 1'b0;
            rd = {rd[14:0], mdio_i};
        end
    endtask

    task automatic check_read(input logic [4:0] ra, input logic [15:0] exp);
        logic [15:0] got;
        read_frame(dut_phy, ra, got);
        rd_reg = ra;
        rd_got = got;
        rd_exp = exp;
        chk.rd = 1'b1;
        @(negedge mdc);
        chk.rd = 1'b0;
    endtask

    task automatic check_bmsr();
        check_read(reg_bmsr, bmsr_expect(link_m, phy_status.autoneg_done));
        // a status read re-arms the latch to the present link level
        link_m = phy_status.link_up;
    endtask

    task automatic write_reg(input logic [4:0] ra, input logic [15:0] wd);
        write_frame(op_write, dut_phy, ra, wd);
        case (ra)
            reg_test: test_m = wd;
            // soft reset brings back the default word
            reg_bmcr: ctrl_m = wd[15] ? bmcr_reset_val : (wd & bmcr_rw_mask);
            default: ;
        endcase
    endtask

    // write lands one edge after the last data bit, soft reset needs one more
    task automatic check_ctrl();
        repeat (3) @(negedge mdc);
        ctrl_exp = ctrl_of_word(ctrl_m);
        chk.ctrl = 1'b1;
        @(negedge mdc);
        chk.ctrl = 1'b0;
    endtask

    task automatic ignored_frame(input logic [1:0] op, input logic [4:0] phy,
                                 input logic [4:0] ra, input logic [15:0] wd);
        logic [15:0] dummy;
        chk.ign = 1'b1;
        if (op == op_read) begin
            read_frame(phy, ra, dummy);
        end else begin
            write_frame(op, phy, ra, wd);
        end
        @(negedge mdc);
        chk.ign = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (test_fails == 0) begin
            pass_cnt = pass_cnt + 1;
            $display("test %s: ok", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %s: %0d check(s) failed", name, test_fails);
        end
        test_fails = 0;
    endtask

    initial begin
        logic [31:0] r;
        m_oe = 1'b1;
        m_out = 1'b1;
        phy_status = '{link_up: 1'b1, autoneg_done: 1'b1};
        chk = '0;
        ctrl_exp = '0;
        void'($urandom(78368));
        // model state after reset, the link latch starts cleared
        test_m = '0;
        ctrl_m = bmcr_reset_val;
        link_m = 1'b0;
        @(posedge rst_n);
        @(negedge mdc);

        chk.reset = 1'b1;
        @(negedge mdc);
        chk.reset = 1'b0;
        end_test("reset levels");

        check_read(reg_phyid1, phyid1_val);
        check_read(reg_phyid2, phyid2_val);
        end_test("phy identifiers");

        for (int n = 0; n < 8; n++) begin
            r = $urandom();
            write_reg(reg_test, r[15:0]);
            check_read(reg_test, test_m);
        end
        end_test("test register");

        // loopback with both speed bits, duplex bit is not kept
        write_reg(reg_bmcr, 16'h6140);
        check_ctrl();
        check_read(reg_bmcr, ctrl_m);
        write_reg(reg_bmcr, 16'h8800);
        check_ctrl();
        check_read(reg_bmcr, ctrl_m);
        end_test("control and soft reset");

        r = $urandom();
        ignored_frame(op_write, other_phy, reg_test, r[15:0]);
        ignored_frame(op_read, other_phy, reg_test, 16'h0000);
        ignored_frame(2'b11, dut_phy, reg_test, ~test_m);
        ignored_frame(2'b00, dut_phy, reg_bmcr, 16'h0000);
        check_read(reg_test, test_m);
        check_read(reg_bmcr, ctrl_m);
        check_ctrl();
        end_test("ignored frames");

        // first read still shows the latch cleared by reset
        check_bmsr();
        check_bmsr();
        phy_status.link_up = 1'b0;
        link_m = 1'b0;
        repeat (3) @(negedge mdc);
        phy_status.link_up = 1'b1;
        check_bmsr();
        check_bmsr();
        end_test("link latch");

        r = $urandom();
        write_reg(reg_unused, r[15:0]);
        check_read(reg_unused, 16'h0000);
        end_test("unimplemented address");

        $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/mdio_frame_pkg.sv
logic/phy_regs_pkg.sv
logic/mdio_frame_engine.sv
logic/phy_mgmt_regs.sv
logic/phy_mgmt_top.sv
bench/mdc_clock_gen.sv
bench/phy_mgmt_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = phy_mgmt_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
